// File: Bender.yml
package:
  name: tcm_subsystem

sources:
  - files:
      - tcm_pkg.sv
      - tcm_arbiter.sv
      - tcm_bank.sv
      - tcm_resp_router.sv
      - tcm_subsystem.sv
  - target: test
    files:
      - tcm_subsystem_props.sv
      - tb_tcm_subsystem.sv

// File: files.f
tcm_pkg.sv
tcm_arbiter.sv
tcm_bank.sv
tcm_resp_router.sv
tcm_subsystem.sv
tcm_subsystem_props.sv
tb_tcm_subsystem.sv

// File: tb_tcm_subsystem.sv
`timescale 1ns/1ps
/* Testbench for the TCM subsystem, random stimulus from a Galois LFSR
   Model covers a 16-word window at the bottom of each bank
   One idle cycle separates the accesses of a port */
module tb_tcm_subsystem;

   localparam int ADDR_WIDTH = 12;
   // Cycles a port waits for ready
   localparam int TIMEOUT    = 20;
   localparam int WINDOW     = 16;

   logic                              clk;
   logic                              rst_n;
   logic [tcm_pkg::DATA_WIDTH-1:0]    code_addr;
   logic                              code_req;
   logic [tcm_pkg::DATA_WIDTH-1:0]    code_rdata;
   logic                              code_ready;
   logic [tcm_pkg::DATA_WIDTH-1:0]    data_addr;
   logic [tcm_pkg::DATA_WIDTH-1:0]    data_wdata;
   logic [tcm_pkg::DATA_WIDTH/8-1:0]  data_bytesel;
   logic                              data_req;
   logic [tcm_pkg::DATA_WIDTH-1:0]    data_rdata;
   logic                              data_ready;

   // Reference contents of both windows
   logic [tcm_pkg::DATA_WIDTH-1:0] code_model [WINDOW];
   logic [tcm_pkg::DATA_WIDTH-1:0] data_model [WINDOW];

   logic [31:0] lfsr = 32'h224c32e2;
   string       cur_test;
   int          test_errors;
   int          total_errors;
   int          tests_run;
   int          tests_failed;
   int          checks;

   tcm_subsystem #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .code_addr    (code_addr),
      .code_req     (code_req),
      .code_rdata   (code_rdata),
      .code_ready   (code_ready),
      .data_addr    (data_addr),
      .data_wdata   (data_wdata),
      .data_bytesel (data_bytesel),
      .data_req     (data_req),
      .data_rdata   (data_rdata),
      .data_ready   (data_ready)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // One LFSR step per bit, shifted-out bit is the random bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        out_bit;
      val = '0;
      for (int i = 0; i < n; i++) begin
         out_bit = lfsr[0];
         lfsr    = lfsr >> 1;
         if (out_bit) begin
            lfsr = lfsr ^ 32'hD000_0001;
         end
         val = {val[30:0], out_bit};
      end
      return val;
   endfunction

   // Four random bits as a nibble
   function automatic logic [3:0] rand_nibble();
      logic [31:0] val;
      val = rand_bits(4);
      return val[3:0];
   endfunction

   // Region nibble, random undecoded middle bits, word index inside the window
   function automatic logic [31:0] make_addr(input logic [3:0] region, input logic [3:0] idx);
      logic [31:0] mid;
      mid = rand_bits(16);
      return {region, mid[15:0], 6'd0, idx, 2'b00};
   endfunction

   // Unmapped regions read as zero
   function automatic logic [31:0] model_read(input logic [31:0] addr);
      case (addr[31:28])
         tcm_pkg::REGION_CODE: return code_model[addr[5:2]];
         tcm_pkg::REGION_DATA: return data_model[addr[5:2]];
         default:              return '0;
      endcase
   endfunction

   function automatic void model_write(input logic [31:0] addr, input logic [31:0] wdata,
                                       input logic [3:0] sel);
      logic [31:0] word;
      word = model_read(addr);
      for (int i = 0; i < 4; i++) begin
         if (sel[i]) begin
            word[8*i +: 8] = wdata[8*i +: 8];
         end
      end
      // Writes to unmapped space vanish
      if (addr[31:28] == tcm_pkg::REGION_CODE) begin
         code_model[addr[5:2]] = word;
      end else if (addr[31:28] == tcm_pkg::REGION_DATA) begin
         data_model[addr[5:2]] = word;
      end
   endfunction

   task automatic compare_word(input string label, input logic [tcm_pkg::DATA_WIDTH-1:0] exp,
                               input logic [tcm_pkg::DATA_WIDTH-1:0] act);
      checks++;
      if (act !== exp) begin
         $display("CHECK FAILED %s %s: expected %h actual %h", cur_test, label, exp, act);
         test_errors++;
      end
   endtask

   task automatic compare_ready(input string label, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         $display("CHECK FAILED %s %s: expected %b actual %b", cur_test, label, exp, act);
         test_errors++;
      end
   endtask

   // Load when sel is zero, store otherwise
   // exp_first is the ready expected one cycle after the request
   task automatic data_op(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] sel, input logic exp_first);
      logic first;
      int   n;
      @(negedge clk);
      data_addr    = addr;
      data_wdata   = wdata;
      data_bytesel = sel;
      data_req     = 1'b1;
      n            = 0;
      do begin
         @(negedge clk);
         n++;
         if (n == 1) begin
            first = data_ready;
         end
      end while (!data_ready && n < TIMEOUT);
      data_req = 1'b0;
      if (!data_ready) begin
         $display("Timeout in %s: data port got no ready for address %h", cur_test, addr);
         test_errors++;
      end else begin
         compare_ready($sformatf("data ready latency %h", addr), exp_first, first);
         if (sel == '0) begin
            compare_word($sformatf("load %h", addr), model_read(addr), data_rdata);
         end else begin
            model_write(addr, wdata, sel);
         end
      end
   endtask

   task automatic code_op(input logic [31:0] addr, input logic exp_first);
      logic first;
      int   n;
      @(negedge clk);
      code_addr = addr;
      code_req  = 1'b1;
      n         = 0;
      do begin
         @(negedge clk);
         n++;
         if (n == 1) begin
            first = code_ready;
         end
      end while (!code_ready && n < TIMEOUT);
      code_req = 1'b0;
      if (!code_ready) begin
         $display("Timeout in %s: code port got no ready for address %h", cur_test, addr);
         test_errors++;
      end else begin
         compare_ready($sformatf("code ready latency %h", addr), exp_first, first);
         compare_word($sformatf("fetch %h", addr), model_read(addr), code_rdata);
      end
   endtask

   task automatic start_test(input string name);
      cur_test    = name;
      test_errors = 0;
   endtask

   task automatic finish_test();
      tests_run++;
      total_errors += test_errors;
      if (test_errors == 0) begin
         $display("test %s ok", cur_test);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", cur_test, test_errors);
      end
   endtask

   initial begin
      logic [31:0] addr;
      logic [31:0] caddr;
      logic [3:0]  region;
      rst_n        = 1'b0;
      code_addr    = '0;
      code_req     = 1'b0;
      data_addr    = '0;
      data_wdata   = '0;
      data_bytesel = '0;
      data_req     = 1'b0;
      total_errors = 0;
      tests_run    = 0;
      tests_failed = 0;
      checks       = 0;
      for (int i = 0; i < 3; i++) begin
         @(posedge clk);
      end
      @(negedge clk);
      rst_n = 1'b1;

      // Quiet ports until the first request
      start_test("reset_idle");
      for (int i = 0; i < 4; i++) begin
         @(negedge clk);
         compare_ready("code idle", 1'b0, code_ready);
         compare_ready("data idle", 1'b0, data_ready);
      end
      addr = make_addr(tcm_pkg::REGION_DATA, 4'd0);
      data_op(addr, rand_bits(32), 4'hF, 1'b1);
      data_op(addr, '0, 4'h0, 1'b1);
      finish_test();

      start_test("data_bank_bytes");
      for (int i = 0; i < WINDOW; i++) begin
         data_op(make_addr(tcm_pkg::REGION_DATA, i[3:0]), rand_bits(32), 4'hF, 1'b1);
      end
      // Zero bytesel turns the op into a load
      for (int i = 0; i < 40; i++) begin
         addr = make_addr(tcm_pkg::REGION_DATA, rand_nibble());
         data_op(addr, rand_bits(32), rand_nibble(), 1'b1);
      end
      for (int i = 0; i < WINDOW; i++) begin
         data_op(make_addr(tcm_pkg::REGION_DATA, i[3:0]), '0, 4'h0, 1'b1);
      end
      finish_test();

      start_test("code_bank_fetch");
      for (int i = 0; i < WINDOW; i++) begin
         data_op(make_addr(tcm_pkg::REGION_CODE, i[3:0]), rand_bits(32), 4'hF, 1'b1);
      end
      for (int i = 0; i < WINDOW; i++) begin
         code_op(make_addr(tcm_pkg::REGION_CODE, rand_nibble()), 1'b1);
         code_op(make_addr(tcm_pkg::REGION_DATA, rand_nibble()), 1'b1);
      end
      finish_test();

      // Data port first, fetch retried after the bank frees
      start_test("same_bank_conflict");
      for (int i = 0; i < 8; i++) begin
         region = rand_bits(1) ? tcm_pkg::REGION_DATA : tcm_pkg::REGION_CODE;
         addr   = make_addr(region, rand_nibble());
         caddr  = make_addr(region, rand_nibble());
         fork
            data_op(addr, rand_bits(32), rand_nibble(), 1'b1);
            code_op(caddr, 1'b0);
         join
      end
      finish_test();

      start_test("cross_access");
      for (int i = 0; i < 8; i++) begin
         addr  = make_addr(tcm_pkg::REGION_CODE, rand_nibble());
         caddr = make_addr(tcm_pkg::REGION_DATA, rand_nibble());
         fork
            data_op(addr, rand_bits(32), rand_nibble(), 1'b1);
            code_op(caddr, 1'b1);
         join
      end
      finish_test();

      start_test("unmapped_space");
      for (int i = 0; i < 12; i++) begin
         region = (i == 0) ? 4'hF : rand_nibble();
         if (region == tcm_pkg::REGION_CODE || region == tcm_pkg::REGION_DATA) begin
            region = 4'hF;
         end
         addr = make_addr(region, rand_nibble());
         data_op(addr, rand_bits(32), 4'hF, 1'b1);
         data_op(addr, '0, 4'h0, 1'b1);
         code_op(addr, 1'b1);
      end
      // Both windows must be untouched
      for (int i = 0; i < WINDOW; i++) begin
         data_op(make_addr(tcm_pkg::REGION_DATA, i[3:0]), '0, 4'h0, 1'b1);
         data_op(make_addr(tcm_pkg::REGION_CODE, i[3:0]), '0, 4'h0, 1'b1);
      end
      finish_test();

      total_errors += uut.u_props.fail_count;
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, total_errors);
      if (total_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: tcm_arbiter.sv
`timescale 1ns/1ps
/* Steers the code and data ports onto the two TCM banks, the data port always wins
   Peripheral and unmapped regions never enable a bank
   Code port is read only, so its bank bytesel is forced to zero */
module tcm_arbiter #(
   parameter int ADDR_WIDTH = 12
) (
   // Code port
   input  logic [tcm_pkg::DATA_WIDTH-1:0]                         code_addr,
   input  logic                                                   code_req,
   // Data port
   input  logic [tcm_pkg::DATA_WIDTH-1:0]                         data_addr,
   input  logic [tcm_pkg::DATA_WIDTH-1:0]                         data_wdata,
   input  logic [tcm_pkg::DATA_WIDTH/8-1:0]                       data_bytesel,
   input  logic                                                   data_req,
   // Bank request side
   output logic [tcm_pkg::NUM_BANKS-1:0]                          bank_en,
   output logic [tcm_pkg::NUM_BANKS-1:0][ADDR_WIDTH-1:0]          bank_addr,
   output logic [tcm_pkg::NUM_BANKS-1:0][tcm_pkg::DATA_WIDTH-1:0] bank_din,
   output logic [tcm_pkg::NUM_BANKS-1:0][tcm_pkg::DATA_WIDTH/8-1:0] bank_bytesel,
   // 1 means the data port drives this bank, 0 the code port
   output logic [tcm_pkg::NUM_BANKS-1:0]                          bank_owner,
   // Status for the response router
   output logic                                                   code_blocked,
   output logic                                                   code_periph,
   output logic                                                   data_periph
);

   // Two views of each incoming address
   tcm_pkg::tcm_addr_u code_word;
   tcm_pkg::tcm_addr_u data_word;

   // One-hot bank picked by the address alone
   logic [tcm_pkg::NUM_BANKS-1:0] code_sel;
   logic [tcm_pkg::NUM_BANKS-1:0] data_sel;

   // Same, qualified by the request
   logic [tcm_pkg::NUM_BANKS-1:0] code_hit;
   logic [tcm_pkg::NUM_BANKS-1:0] data_hit;

   // Banks actually handed to the fetch
   logic [tcm_pkg::NUM_BANKS-1:0] code_gnt;

   // Region nibble to one-hot bank, all zero for peripheral space
   function automatic logic [tcm_pkg::NUM_BANKS-1:0] region_sel(input logic [3:0] region);
      logic [tcm_pkg::NUM_BANKS-1:0] sel;
      sel = '0;
      case (region)
         tcm_pkg::REGION_CODE: sel[tcm_pkg::BANK_CODE] = 1'b1;
         tcm_pkg::REGION_DATA: sel[tcm_pkg::BANK_DATA] = 1'b1;
         // Region F and every unmapped nibble
         default:              sel = '0;
      endcase
      return sel;
   endfunction

   always_comb begin
      code_word.raw = code_addr;
      data_word.raw = data_addr;
   end

   // Region decode
   assign code_sel = region_sel(code_word.fields.region);
   assign data_sel = region_sel(data_word.fields.region);

   // Address-only decode, the router adds the request
   assign code_periph = ~|code_sel;
   assign data_periph = ~|data_sel;

   assign code_hit = code_sel & {tcm_pkg::NUM_BANKS{code_req}};
   assign data_hit = data_sel & {tcm_pkg::NUM_BANKS{data_req}};

   // Priority table, the data port is granted whatever it hits
   //   data->dbank  data->cbank  code->dbank  code->cbank
   //        1            0            0            1      no conflict
   //        1            0            1            0      data wins, fetch waits
   //        0            1            1            0      cross grant
   //        0            1            0            1      data wins, fetch waits
   //        x            x            x            x      lone access, nothing to resolve
   always_comb begin
      code_gnt     = code_hit;
      code_blocked = 1'b0;
      if (data_hit[tcm_pkg::BANK_DATA] && code_hit[tcm_pkg::BANK_DATA]) begin
         // Both in data RAM
         code_gnt     = '0;
         code_blocked = 1'b1;
      end else if (data_hit[tcm_pkg::BANK_CODE] && code_hit[tcm_pkg::BANK_CODE]) begin
         // Load or store into code RAM holds off the fetch
         code_gnt     = '0;
         code_blocked = 1'b1;
      end
   end

   // Per-bank mux onto the winning port
   always_comb begin
      for (int b = 0; b < tcm_pkg::NUM_BANKS; b++) begin
         bank_en[b]    = data_hit[b] | code_gnt[b];
         bank_owner[b] = data_hit[b];
         if (data_hit[b]) begin
            bank_addr[b]    = data_word.raw[ADDR_WIDTH-1:0];
            bank_din[b]     = data_wdata;
            bank_bytesel[b] = data_bytesel;
         end else begin
            // Fetch or idle, always a read
            bank_addr[b]    = code_word.raw[ADDR_WIDTH-1:0];
            bank_din[b]     = '0;
            bank_bytesel[b] = '0;
         end
      end
   end

endmodule

// File: tcm_bank.sv
`timescale 1ns/1ps
/* Single-port word RAM with byte writes and a one-cycle ready pulse
   Address bits 1:0 are ignored, accesses are word aligned
   One access per two cycles, bank_en is ignored while ready is high */
module tcm_bank #(
   parameter int ADDR_WIDTH = 12
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              bank_en,
   input  logic [ADDR_WIDTH-1:0]             bank_addr,
   input  logic [tcm_pkg::DATA_WIDTH-1:0]    bank_din,
   // Zero means read
   input  logic [tcm_pkg::DATA_WIDTH/8-1:0]  bank_bytesel,
   output logic [tcm_pkg::DATA_WIDTH-1:0]    bank_dout,
   output logic                              bank_ready
);

   // Words in the bank
   localparam int DEPTH = 2 ** (ADDR_WIDTH - 2);

   logic [tcm_pkg::DATA_WIDTH-1:0] mem [DEPTH];

   // Word index
   logic [ADDR_WIDTH-3:0] word_addr;

   // Request taken this edge
   logic accept;

   assign word_addr = bank_addr[ADDR_WIDTH-1:2];

   // No new access in the ready cycle
   assign accept = bank_en & ~bank_ready;

   // Ready pulse, high for the cycle after acceptance
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bank_ready <= 1'b0;
      end else begin
         bank_ready <= accept;
      end
   end

   // Storage and read register
   always_ff @(posedge clk) begin
      if (accept) begin
         // Read keeps the word for the ready cycle
         if (bank_bytesel == '0) begin
            bank_dout <= mem[word_addr];
         end
         // Byte merge under bytesel
         for (int i = 0; i < tcm_pkg::DATA_WIDTH / 8; i++) begin
            if (bank_bytesel[i]) begin
               mem[word_addr][8*i +: 8] <= bank_din[8*i +: 8];
            end
         end
      end
   end

endmodule

// File: tcm_pkg.sv
/* Shared constants and the address view of the TCM subsystem
   Only the top address nibble selects a region, all other nibbles are peripheral space */
package tcm_pkg;

   // Width of data words and of CPU addresses
   parameter int DATA_WIDTH = 32;

   // Region nibbles in address bits 31:28
   // Code TCM
   parameter logic [3:0] REGION_CODE = 4'h0;
   // Data TCM
   parameter logic [3:0] REGION_DATA = 4'h2;

   // Number of memory banks behind the arbiter
   parameter int NUM_BANKS = 2;

   // Bank slots in the generate loop and in every per-bank vector
   parameter int BANK_CODE = 0;
   parameter int BANK_DATA = 1;

   // One address word, seen either as the raw bus value or split into fields
   // Raw view feeds the bank address
   // Field view feeds the region decode
   typedef union packed {
      logic [DATA_WIDTH-1:0] raw;
      struct packed {
         // Region select
         logic [3:0]  region;
         // Not decoded by the TCMs
         logic [15:0] unused;
         // Byte offset inside a 4 KiB bank
         logic [11:0] offset;
      } fields;
   } tcm_addr_u;

endpackage

// File: tcm_resp_router.sv
`timescale 1ns/1ps
/* Returns bank read data and ready pulses to the port that owned each access
   Peripheral and unmapped requests read zero one cycle after they are seen
   A held peripheral request completes once every two cycles */
module tcm_resp_router (
   input  logic                                                   clk,
   input  logic                                                   rst_n,
   // From the banks
   input  logic [tcm_pkg::NUM_BANKS-1:0][tcm_pkg::DATA_WIDTH-1:0] bank_dout,
   input  logic [tcm_pkg::NUM_BANKS-1:0]                          bank_ready,
   // From the arbiter, owner 1 is the data port
   input  logic [tcm_pkg::NUM_BANKS-1:0]                          bank_owner,
   input  logic                                                   code_blocked,
   input  logic                                                   code_periph,
   input  logic                                                   data_periph,
   // Port requests
   input  logic                                                   code_req,
   input  logic                                                   data_req,
   // Port responses
   output logic [tcm_pkg::DATA_WIDTH-1:0]                         code_rdata,
   output logic                                                   code_ready,
   output logic [tcm_pkg::DATA_WIDTH-1:0]                         data_rdata,
   output logic                                                   data_ready
);

   // Owner of the access in flight per bank
   logic [tcm_pkg::NUM_BANKS-1:0] owner_q;

   // Bank readies split by owner
   logic [tcm_pkg::NUM_BANKS-1:0] code_bank_rdy;
   logic [tcm_pkg::NUM_BANKS-1:0] data_bank_rdy;

   // Zero-data responses from peripheral space
   logic code_periph_rdy;
   logic data_periph_rdy;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         owner_q         <= '0;
         code_periph_rdy <= 1'b0;
         data_periph_rdy <= 1'b0;
      end else begin
         // A bank accepts only while its ready is low
         // so the owner is frozen over the ready cycle
         for (int b = 0; b < tcm_pkg::NUM_BANKS; b++) begin
            if (!bank_ready[b]) begin
               owner_q[b] <= bank_owner[b];
            end
         end
         // Blocked fetch never takes the zero response
         code_periph_rdy <= code_req & code_periph & ~code_blocked & ~code_periph_rdy;
         data_periph_rdy <= data_req & data_periph & ~data_periph_rdy;
      end
   end

   assign code_bank_rdy = bank_ready & ~owner_q;
   assign data_bank_rdy = bank_ready & owner_q;

   // Cross grant gives both ports a pulse in the same cycle
   assign code_ready = (|code_bank_rdy) | code_periph_rdy;
   assign data_ready = (|data_bank_rdy) | data_periph_rdy;

   // Read data mux, zero when no bank answers this port
   always_comb begin
      code_rdata = '0;
      data_rdata = '0;
      for (int b = 0; b < tcm_pkg::NUM_BANKS; b++) begin
         if (code_bank_rdy[b]) begin
            code_rdata = bank_dout[b];
         end
         if (data_bank_rdy[b]) begin
            data_rdata = bank_dout[b];
         end
      end
   end

endmodule

// File: tcm_subsystem.sv
`timescale 1ns/1ps
/* TCM subsystem top, code TCM in region 0 and data TCM in region 2
   Ports hold req and address until they see ready at a rising edge
   Each bank holds 2**ADDR_WIDTH bytes */
module tcm_subsystem #(
   parameter int ADDR_WIDTH = 12
) (
   input  logic                              clk,
   input  logic                              rst_n,
   // Code port, fetch only
   input  logic [tcm_pkg::DATA_WIDTH-1:0]    code_addr,
   input  logic                              code_req,
   output logic [tcm_pkg::DATA_WIDTH-1:0]    code_rdata,
   output logic                              code_ready,
   // Data port, loads and stores
   input  logic [tcm_pkg::DATA_WIDTH-1:0]    data_addr,
   input  logic [tcm_pkg::DATA_WIDTH-1:0]    data_wdata,
   input  logic [tcm_pkg::DATA_WIDTH/8-1:0]  data_bytesel,
   input  logic                              data_req,
   output logic [tcm_pkg::DATA_WIDTH-1:0]    data_rdata,
   output logic                              data_ready
);

   // Arbiter to banks
   logic [tcm_pkg::NUM_BANKS-1:0]                            bank_en;
   logic [tcm_pkg::NUM_BANKS-1:0][ADDR_WIDTH-1:0]            bank_addr;
   logic [tcm_pkg::NUM_BANKS-1:0][tcm_pkg::DATA_WIDTH-1:0]   bank_din;
   logic [tcm_pkg::NUM_BANKS-1:0][tcm_pkg::DATA_WIDTH/8-1:0] bank_bytesel;

   // Banks to router
   logic [tcm_pkg::NUM_BANKS-1:0][tcm_pkg::DATA_WIDTH-1:0]   bank_dout;
   logic [tcm_pkg::NUM_BANKS-1:0]                            bank_ready;

   // Arbiter to router
   logic [tcm_pkg::NUM_BANKS-1:0]                            bank_owner;
   logic                                                     code_blocked;
   logic                                                     code_periph;
   logic                                                     data_periph;

   tcm_arbiter #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) u_arbiter (
      .code_addr    (code_addr),
      .code_req     (code_req),
      .data_addr    (data_addr),
      .data_wdata   (data_wdata),
      .data_bytesel (data_bytesel),
      .data_req     (data_req),
      .bank_en      (bank_en),
      .bank_addr    (bank_addr),
      .bank_din     (bank_din),
      .bank_bytesel (bank_bytesel),
      .bank_owner   (bank_owner),
      .code_blocked (code_blocked),
      .code_periph  (code_periph),
      .data_periph  (data_periph)
   );

   // Slot BANK_CODE is the code TCM, slot BANK_DATA the data TCM
   for (genvar b = 0; b < tcm_pkg::NUM_BANKS; b++) begin : g_bank
      tcm_bank #(
         .ADDR_WIDTH (ADDR_WIDTH)
      ) u_bank (
         .clk          (clk),
         .rst_n        (rst_n),
         .bank_en      (bank_en[b]),
         .bank_addr    (bank_addr[b]),
         .bank_din     (bank_din[b]),
         .bank_bytesel (bank_bytesel[b]),
         .bank_dout    (bank_dout[b]),
         .bank_ready   (bank_ready[b])
      );
   end

   tcm_resp_router u_router (
      .clk          (clk),
      .rst_n        (rst_n),
      .bank_dout    (bank_dout),
      .bank_ready   (bank_ready),
      .bank_owner   (bank_owner),
      .code_blocked (code_blocked),
      .code_periph  (code_periph),
      .data_periph  (data_periph),
      .code_req     (code_req),
      .data_req     (data_req),
      .code_rdata   (code_rdata),
      .code_ready   (code_ready),
      .data_rdata   (data_rdata),
      .data_ready   (data_ready)
   );

endmodule

// File: tcm_subsystem_props.sv
`timescale 1ns/1ps
/* Handshake and write-path assertions, bound into every tcm_subsystem
   Checks are idle while rst_n is low */
module tcm_subsystem_props (
   input logic                                                     clk,
   input logic                                                     rst_n,
   input logic                                                     code_req,
   input logic                                                     code_ready,
   input logic                                                     data_req,
   input logic                                                     data_ready,
   input logic [tcm_pkg::NUM_BANKS-1:0]                            bank_en,
   input logic [tcm_pkg::NUM_BANKS-1:0]                            bank_owner,
   input logic [tcm_pkg::NUM_BANKS-1:0][tcm_pkg::DATA_WIDTH/8-1:0] bank_bytesel
);

   // Number of failed assertions so far
   int fail_count = 0;

   // Ready is a single-cycle pulse
   ap_code_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      code_ready |=> !code_ready)
      else begin
         fail_count++;
         $error("code_ready held high for two cycles");
      end

   ap_data_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      data_ready |=> !data_ready)
      else begin
         fail_count++;
         $error("data_ready held high for two cycles");
      end

   // Request seen one edge before its ready
   ap_code_req: assert property (@(posedge clk) disable iff (!rst_n)
      code_ready |-> $past(code_req))
      else begin
         fail_count++;
         $error("code_ready without a code request");
      end

   ap_data_req: assert property (@(posedge clk) disable iff (!rst_n)
      data_ready |-> $past(data_req))
      else begin
         fail_count++;
         $error("data_ready without a data request");
      end

   // Fetches into code RAM are always reads
   ap_code_no_write: assert property (@(posedge clk) disable iff (!rst_n)
      (bank_en[tcm_pkg::BANK_CODE] && !bank_owner[tcm_pkg::BANK_CODE])
         |-> (bank_bytesel[tcm_pkg::BANK_CODE] == '0))
      else begin
         fail_count++;
         $error("code port drove a write strobe into the code bank");
      end

endmodule

bind tcm_subsystem tcm_subsystem_props u_props (
   .clk          (clk),
   .rst_n        (rst_n),
   .code_req     (code_req),
   .code_ready   (code_ready),
   .data_req     (data_req),
   .data_ready   (data_ready),
   .bank_en      (bank_en),
   .bank_owner   (bank_owner),
   .bank_bytesel (bank_bytesel)
);
